// File: common/vec_op_if.sv
// One operation in flight between the operand stage and the result stage
// Valid/ready handshake, valid holds with its payload until the transfer
`timescale 1ns/100ps

interface vec_op_if
    import vec_pkg::*;
();

    logic       valid;
    logic       ready;
    vec_funct_t funct;
    vec_mask_t  mask;
    vec_data_t  src_a;
    vec_data_t  src_b;

    modport producer (output valid, funct, mask, src_a, src_b, input ready);
    modport consumer (input valid, funct, mask, src_a, src_b, output ready);

endinterface

// File: common/vec_pkg.sv
// Shared widths, vector types and function codes for the vector permute unit
// Imported by every RTL file of the unit

package vec_pkg;

    // ====================
    // Geometry
    // ====================
    localparam int num_lanes  = 8;
    localparam int lane_width = 64;
    localparam int vec_width  = num_lanes * lane_width;  // 512

    // ====================
    // Data types
    // ====================
    typedef logic [lane_width-1:0]          vec_word_t;   // One lane
    typedef logic [vec_width-1:0]           vec_data_t;   // Lane i at bits i*64 +: 64
    typedef logic [num_lanes-1:0]           vec_mask_t;   // Bit i gates lane i
    typedef logic [$clog2(num_lanes)-1:0]   lane_idx_t;   // Low bits of a b-lane
    typedef logic [$clog2(lane_width)-1:0]  shift_amt_t;  // Shift or rotate amount

    // ====================
    // Function codes
    // ====================
    // Codes 0-5, 9 and F are not supported and come out flagged as illegal
    typedef enum logic [3:0] {
        funct_gather   = 4'h6,
        funct_scatter  = 4'h7,
        funct_shuffle  = 4'h8,
        funct_blend    = 4'hA,
        funct_shl      = 4'hB,
        funct_rotl     = 4'hC,
        funct_compress = 4'hD,
        funct_expand   = 4'hE
    } vec_funct_t;

endpackage

// File: flist.f
+incdir+testbench
common/vec_pkg.sv
common/vec_op_if.sv
vector_unit/vec_operand_stage.sv
vector_unit/vec_lane_alu.sv
vector_unit/vec_permute_net.sv
vector_unit/vec_result_stage.sv
src/vec_unit_top.sv
testbench/tb_vec_unit.sv

// File: run_verilator.sh
#!/bin/sh
# Builds the vector unit testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f flist.f --top-module tb_vec_unit -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_vec_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

// File: src/vec_unit_top.sv
// Top level of the 8x64 vector permute and shift unit
// Two-stage pipeline, valid/ready on both the input and the output side
`timescale 1ns/100ps

module vec_unit_top
    import vec_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  vec_funct_t funct,
    input  vec_mask_t  mask,
    input  vec_data_t  src_a,
    input  vec_data_t  src_b,
    output logic       out_valid,
    input  logic       out_ready,
    output vec_data_t  result,
    output logic       illegal_op
);

    vec_op_if op_if ();  // Operand stage to result stage

    vec_operand_stage i_operand_stage (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .funct    (funct),
        .mask     (mask),
        .src_a    (src_a),
        .src_b    (src_b),
        .op       (op_if.producer)
    );

    vec_result_stage i_result_stage (
        .clk        (clk),
        .reset      (reset),
        .op         (op_if.consumer),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .result     (result),
        .illegal_op (illegal_op)
    );

endmodule

// File: testbench/tb_vec_model.svh
// Reference model and value check for the vector unit testbench
// Included inside the testbench module, after the vec_pkg import
`ifndef TB_VEC_MODEL_SVH
`define TB_VEC_MODEL_SVH

typedef struct packed {
    logic      illegal;
    vec_data_t data;
} model_out_t;

// Expected result of one operation, worked out lane by lane
function automatic model_out_t vec_model(logic [3:0] code, vec_mask_t m,
                                         vec_data_t a, vec_data_t b);
    vec_word_t  al [num_lanes];
    vec_word_t  bl [num_lanes];
    vec_word_t  rl [num_lanes];
    model_out_t o;
    int         k;
    int         sh;
    k         = 0;
    o.illegal = 1'b0;
    for (int i = 0; i < num_lanes; i++) begin
        al[i] = a[i*lane_width +: lane_width];
        bl[i] = b[i*lane_width +: lane_width];
        rl[i] = '0;
    end
    for (int i = 0; i < num_lanes; i++) begin
        sh = int'(bl[i][5:0]);
        case (code)
            4'h6: rl[i] = m[i] ? al[bl[i][2:0]] : al[i];      // Gather
            4'h7: if (m[i]) rl[bl[i][2:0]] = al[i];          // Scatter, higher lane wins
            4'h8: rl[i] = al[bl[i][2:0]];                     // Shuffle
            4'hA: rl[i] = m[i] ? al[i] : bl[i];               // Blend
            4'hB: rl[i] = al[i] << sh;
            4'hC: rl[i] = (sh == 0) ? al[i] : (al[i] << sh) | (al[i] >> (lane_width - sh));
            4'hD: begin
                if (m[i]) begin
                    rl[k] = al[i];                            // Pack downward
                    k++;
                end
            end
            4'hE: begin
                if (m[i]) begin
                    rl[i] = al[k];                            // Next source lane
                    k++;
                end
            end
            default: o.illegal = 1'b1;
        endcase
    end
    for (int i = 0; i < num_lanes; i++) begin
        o.data[i*lane_width +: lane_width] = rl[i];
    end
    return o;
endfunction

task automatic check_value(string name, vec_data_t expected, vec_data_t actual);
    if (actual !== expected) begin
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

`endif

// File: testbench/tb_vec_unit.sv
// Testbench for the vector permute and shift unit
// Directed and random rows from a table, checked against a reference model
`timescale 1ns/100ps

module tb_vec_unit
    import vec_pkg::*;
();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int num_directed = 19;
    localparam int num_rows     = 64;

    typedef struct packed {
        logic [3:0] funct;
        vec_mask_t  mask;
        vec_data_t  src_a;
        vec_data_t  src_b;
        logic       illegal;
    } row_t;

    typedef struct packed {
        vec_data_t   data;
        logic        illegal;
        logic [31:0] cycle;                  // Edge count at input transfer
        logic        timed;                  // Latency is checked
    } expect_t;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    vec_funct_t funct;
    vec_mask_t  mask;
    vec_data_t  src_a;
    vec_data_t  src_b;
    logic       out_valid;
    logic       out_ready;
    vec_data_t  result;
    logic       illegal_op;

    row_t        rows [num_rows];
    expect_t     expect_q [$];
    logic [31:0] rng_state = 32'h7974_c2fb;
    logic [31:0] cycle     = '0;
    int          n_rows    = 0;
    int          n_acc     = 0;
    logic        bp_enable = 1'b0;

    `include "tb_vec_model.svh"

    vec_unit_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .funct      (funct),
        .mask       (mask),
        .src_a      (src_a),
        .src_b      (src_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .result     (result),
        .illegal_op (illegal_op)
    );

    // ====================
    // Stimulus helpers
    // ====================
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x         = rng_state;
        x         = x ^ (x << 13);
        x         = x ^ (x >> 17);
        x         = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic vec_data_t random_vec();
        vec_data_t v;
        for (int i = 0; i < vec_width / 32; i++) begin
            v[i*32 +: 32] = next_random();
        end
        return v;
    endfunction

    function automatic vec_data_t lanes_from(vec_word_t base);
        vec_data_t v;
        for (int i = 0; i < num_lanes; i++) begin
            v[i*lane_width +: lane_width] = base + vec_word_t'(i) * 64'h1111_0000_0101_0011;
        end
        return v;
    endfunction

    // Same amount in every lane, junk above bit 5
    function automatic vec_data_t shift_vec(logic [5:0] amt);
        return {num_lanes{{58'h2AA_5555_0F0F, amt}}};
    endfunction

    // Lane i index from idx[3i +: 3], junk above bit 2
    function automatic vec_data_t index_vec(logic [23:0] idx);
        vec_data_t v;
        for (int i = 0; i < num_lanes; i++) begin
            v[i*lane_width +: lane_width] = {61'h0BAD_F00D_CAFE, idx[i*3 +: 3]};
        end
        return v;
    endfunction

    task automatic add_row(logic [3:0] code, vec_mask_t m, vec_data_t a, vec_data_t b,
                           logic ill);
        rows[n_rows] = {code, m, a, b, ill};
        n_rows++;
    endtask

    task automatic fill_rows();
        vec_data_t   a;
        vec_data_t   b;
        logic [31:0] rnd;
        model_out_t  exp;
        a = lanes_from(64'h8123_4567_89AB_CDEF);
        add_row(4'hB, 8'h00, a, shift_vec(6'd0), 1'b0);
        add_row(4'hB, 8'hFF, a, shift_vec(6'd1), 1'b0);
        add_row(4'hB, 8'h3C, a, shift_vec(6'd63), 1'b0);
        add_row(4'hC, 8'h00, a, shift_vec(6'd0), 1'b0);
        add_row(4'hC, 8'h5A, a, shift_vec(6'd63), 1'b0);
        add_row(4'hA, 8'hA5, a, lanes_from(64'h0F0F_1234_F0F0_5678), 1'b0);
        // Lanes 7..0 index 3,3,0,7,7,1,3,5
        b = index_vec({3'd3, 3'd3, 3'd0, 3'd7, 3'd7, 3'd1, 3'd3, 3'd5});
        add_row(4'h6, 8'hB7, a, b, 1'b0);
        add_row(4'h8, 8'h00, a, b, 1'b0);
        add_row(4'h7, 8'hDB, a, b, 1'b0);    // Collisions on lanes 3 and 7
        add_row(4'hD, 8'h00, a, b, 1'b0);
        add_row(4'hD, 8'hFF, a, b, 1'b0);
        add_row(4'hD, 8'h96, a, b, 1'b0);
        add_row(4'hE, 8'h00, a, b, 1'b0);
        add_row(4'hE, 8'hFF, a, b, 1'b0);
        add_row(4'hE, 8'h96, a, b, 1'b0);
        add_row(4'h0, 8'hFF, random_vec(), random_vec(), 1'b1);
        add_row(4'h5, 8'h0F, random_vec(), random_vec(), 1'b1);
        add_row(4'h9, 8'hF0, random_vec(), random_vec(), 1'b1);
        add_row(4'hF, 8'h81, random_vec(), random_vec(), 1'b1);
        while (n_rows < num_rows) begin
            rnd = next_random();
            a   = random_vec();
            b   = random_vec();
            exp = vec_model(rnd[3:0], rnd[15:8], a, b);
            add_row(rnd[3:0], rnd[15:8], a, b, exp.illegal);
        end
    endtask

    // ====================
    // Clock, edge count, back-pressure, watchdog
    // ====================
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 32'd1;

    initial begin : back_pressure
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            #1;
            if (bp_enable) begin
                rnd       = next_random();
                out_ready = rnd[0];          // Low on about half the cycles
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        #(num_rows * 20 * clk_period + reset_cycles * clk_period);
        $display("Timeout: the run did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1);
    end

    // ====================
    // Scoreboard
    // ====================
    initial begin : monitor
        expect_t    e;
        model_out_t m_out;
        logic       stalled;
        vec_data_t  held_result;
        logic       held_illegal;
        stalled      = 1'b0;
        held_result  = '0;
        held_illegal = 1'b0;
        forever begin
            @(negedge clk);
            if (stalled) begin
                // Output must hold while the consumer stalls
                check_value("out_valid", vec_data_t'(1), vec_data_t'(out_valid));
                check_value("result", held_result, result);
                check_value("illegal_op", vec_data_t'(held_illegal), vec_data_t'(illegal_op));
            end
            stalled      = !reset && out_valid && !out_ready;
            held_result  = result;
            held_illegal = illegal_op;
            if (!reset && in_valid && in_ready) begin
                m_out = vec_model(rows[n_acc].funct, rows[n_acc].mask,
                                  rows[n_acc].src_a, rows[n_acc].src_b);
                e.data    = m_out.data;
                e.illegal = rows[n_acc].illegal;
                e.cycle   = cycle;
                e.timed   = !bp_enable;
                expect_q.push_back(e);
                n_acc++;
            end
            if (!reset && out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("Output transfer at %0t with no operation outstanding", $time);
                    $display("TESTS FAILED");
                    $fatal(1);
                end else begin
                    e = expect_q.pop_front();
                    check_value("result", e.data, result);
                    check_value("illegal_op", vec_data_t'(e.illegal), vec_data_t'(illegal_op));
                    if (e.timed) begin
                        check_value("latency", vec_data_t'(2), vec_data_t'(cycle - e.cycle));
                    end
                end
            end
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        funct     = vec_funct_t'(4'h0);
        mask      = '0;
        src_a     = '0;
        src_b     = '0;
        out_ready = 1'b1;
        fill_rows();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("out_valid", '0, vec_data_t'(out_valid));
        check_value("in_ready", vec_data_t'(1), vec_data_t'(in_ready));
        @(posedge clk);
        #1;
        for (int r = 0; r < num_rows; r++) begin
            if (r == num_directed) begin
                in_valid = 1'b0;             // Drain directed rows first
                do @(posedge clk); while (expect_q.size() != 0);
                bp_enable = 1'b1;
                #1;
            end
            in_valid = 1'b1;
            funct    = vec_funct_t'(rows[r].funct);
            mask     = rows[r].mask;
            src_a    = rows[r].src_a;
            src_b    = rows[r].src_b;
            do @(negedge clk); while (!in_ready);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        @(posedge clk);
        bp_enable = 1'b0;
        repeat (8) @(posedge clk);
        if (expect_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d operations never left the unit", expect_q.size());
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: vector_unit/vec_lane_alu.sv
// Per-lane shift left, rotate left and blend
// Purely combinational, each lane sees only its own a and b lanes
`timescale 1ns/100ps

module vec_lane_alu
    import vec_pkg::*;
(
    input  vec_funct_t funct,
    input  vec_mask_t  mask,
    input  vec_data_t  src_a,
    input  vec_data_t  src_b,
    output vec_data_t  lane_result
);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        vec_word_t               a_lane;
        vec_word_t               b_lane;
        shift_amt_t              amt;
        logic [2*lane_width-1:0] rot_full;
        vec_word_t               res;

        assign a_lane = src_a[i*lane_width +: lane_width];
        assign b_lane = src_b[i*lane_width +: lane_width];
        assign amt    = b_lane[$bits(shift_amt_t)-1:0];

        // Doubled word shifted left, the upper half is the rotation
        assign rot_full = {a_lane, a_lane} << amt;

        always_comb begin
            case (funct)
                funct_shl: begin
                    res = a_lane << amt;              // Logical, mask ignored
                end
                funct_rotl: begin
                    res = rot_full[2*lane_width-1 -: lane_width];
                end
                funct_blend: begin
                    res = mask[i] ? a_lane : b_lane;  // Set bit picks a
                end
                default: begin
                    res = '0;                         // Not a lane op
                end
            endcase
        end

        assign lane_result[i*lane_width +: lane_width] = res;
    end

endmodule

// File: vector_unit/vec_operand_stage.sv
// First pipeline stage: captures an accepted operation and its operands
// and presents it to the result stage over vec_op_if
`timescale 1ns/100ps

module vec_operand_stage
    import vec_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  vec_funct_t funct,
    input  vec_mask_t  mask,
    input  vec_data_t  src_a,
    input  vec_data_t  src_b,
    vec_op_if.producer op
);

    logic       valid_q;
    vec_funct_t funct_q;
    vec_mask_t  mask_q;
    vec_data_t  src_a_q;
    vec_data_t  src_b_q;
    logic       load;

    assign in_ready = !valid_q || op.ready;  // Empty, or draining this cycle
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (op.ready) begin
            valid_q <= 1'b0;                 // Handed on, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            funct_q <= funct;
            mask_q  <= mask;
            src_a_q <= src_a;
            src_b_q <= src_b;
        end
    end

    assign op.valid = valid_q;
    assign op.funct = funct_q;
    assign op.mask  = mask_q;
    assign op.src_a = src_a_q;
    assign op.src_b = src_b_q;

endmodule

// File: vector_unit/vec_permute_net.sv
// Cross-lane network for gather, scatter, shuffle, compress and expand
// Whole 64-bit lanes move, the index of lane i is the low 3 bits of b-lane i
`timescale 1ns/100ps

module vec_permute_net
    import vec_pkg::*;
(
    input  vec_funct_t funct,
    input  vec_mask_t  mask,
    input  vec_data_t  src_a,
    input  vec_data_t  src_b,
    output vec_data_t  perm_result
);

    always_comb begin
        lane_idx_t idx;
        lane_idx_t slot;

        perm_result = '0;
        slot        = '0;

        for (int i = 0; i < num_lanes; i++) begin
            idx = src_b[i*lane_width +: $bits(lane_idx_t)];

            case (funct)
                funct_gather: begin
                    if (mask[i]) begin
                        perm_result[i*lane_width +: lane_width] =
                            src_a[idx*lane_width +: lane_width];
                    end else begin
                        perm_result[i*lane_width +: lane_width] =
                            src_a[i*lane_width +: lane_width];
                    end
                end
                funct_shuffle: begin
                    perm_result[i*lane_width +: lane_width] =
                        src_a[idx*lane_width +: lane_width];
                end
                funct_scatter: begin
                    // Later source lanes overwrite earlier ones
                    if (mask[i]) begin
                        perm_result[idx*lane_width +: lane_width] =
                            src_a[i*lane_width +: lane_width];
                    end
                end
                funct_compress: begin
                    if (mask[i]) begin
                        perm_result[slot*lane_width +: lane_width] =
                            src_a[i*lane_width +: lane_width];
                        slot = slot + 1'b1;             // Next packed position
                    end
                end
                funct_expand: begin
                    if (mask[i]) begin
                        perm_result[i*lane_width +: lane_width] =
                            src_a[slot*lane_width +: lane_width];
                        slot = slot + 1'b1;             // Next source lane
                    end
                end
                default: begin
                    perm_result = '0;                   // Not a permute op
                end
            endcase
        end
    end

endmodule

// File: vector_unit/vec_result_stage.sv
// Second pipeline stage: computes the result of the operation on vec_op_if
// and holds it in the output register until the consumer takes it
`timescale 1ns/100ps

module vec_result_stage
    import vec_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    vec_op_if.consumer op,
    output logic       out_valid,
    input  logic       out_ready,
    output vec_data_t  result,
    output logic       illegal_op
);

    vec_data_t lane_result;
    vec_data_t perm_result;
    vec_data_t next_result;
    logic      next_illegal;
    logic      take;

    vec_lane_alu i_lane_alu (
        .funct       (op.funct),
        .mask        (op.mask),
        .src_a       (op.src_a),
        .src_b       (op.src_b),
        .lane_result (lane_result)
    );

    vec_permute_net i_permute_net (
        .funct       (op.funct),
        .mask        (op.mask),
        .src_a       (op.src_a),
        .src_b       (op.src_b),
        .perm_result (perm_result)
    );

    // ====================
    // Result select
    // ====================
    always_comb begin
        next_illegal = 1'b0;
        case (op.funct)
            funct_blend, funct_shl, funct_rotl: begin
                next_result = lane_result;
            end
            funct_gather, funct_scatter, funct_shuffle, funct_compress, funct_expand: begin
                next_result = perm_result;
            end
            default: begin
                next_result  = '0;              // Unsupported code
                next_illegal = 1'b1;
            end
        endcase
    end

    // ====================
    // Output register
    // ====================
    assign op.ready = !out_valid || out_ready;
    assign take     = op.valid && op.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            illegal_op <= 1'b0;
        end else if (take) begin
            out_valid  <= 1'b1;
            illegal_op <= next_illegal;
        end else if (out_ready) begin
            out_valid  <= 1'b0;                 // Consumed, stage now empty
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result <= next_result;              // Held while out_ready is low
        end
    end

endmodule
